//--- run_sim.sh
#!/usr/bin/env bash
# build and run the exu_ctl testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_exu_ctl \
   -Mdir obj_dir -o sim_exu_ctl
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_exu_ctl > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "sim failed" "$log"; then
   exit 1
fi
exit 0

//--- tests/exu_ctl_tasks.svh
////////////////////////////////////////
// random values and checks
////////////////////////////////////////

function automatic word_t rand_word();
   word_t r;
   r = $random(seed);
   return r;
endfunction

function automatic reg_idx_t rand_idx();
   word_t r;
   r = $random(seed);
   return r[reg_addr_w-1:0];
endfunction

// uniform in 0 .. n-1
function automatic int rand_below(input int n);
   word_t r;
   r = $random(seed);
   return int'(r % word_t'(n));
endfunction

task automatic check_word(input string what, input word_t got, input word_t exp);
   assert (got === exp) else begin
      $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
   end
endtask

////////////////////////////////////////
// expected register file writes
////////////////////////////////////////

// one slot per cycle
wb_t exp_wb  [exp_depth];
bit  exp_set [exp_depth];

// a later call for the same cycle replaces the entry
task automatic expect_wb(input int delay, input logic wen, input reg_idx_t rd, input word_t data);
   logic [slot_w-1:0] slot;
   slot = slot_w'(cyc + delay);
   exp_wb[slot].wen  = wen;
   exp_wb[slot].rd   = rd;
   exp_wb[slot].data = data;
   exp_set[slot]     = 1'b1;
endtask

// moves to the next drive point and checks any write due in this cycle
task automatic tick();
   logic [slot_w-1:0] slot;
   @(posedge clk);
   #1;
   slot = slot_w'(cyc);
   if (exp_set[slot]) begin
      check_word("wb_w wen", word_t'(wb_w.wen), word_t'(exp_wb[slot].wen));
      if (exp_wb[slot].wen) begin
         check_word("wb_w rd", word_t'(wb_w.rd), word_t'(exp_wb[slot].rd));
         check_word("wb_w data", wb_w.data, exp_wb[slot].data);
      end
      exp_set[slot] = 1'b0;
   end
endtask

task automatic clear_inputs();
   issue     = '0;
   req       = '0;
   alu_res   = '0;
   mul_res_m = '0;
   lsu_resp  = '0;
   bru_resp  = '0;
   trap      = '0;
endtask

// plain alu op lands on wb_w two cycles on
task automatic issue_alu(input reg_idx_t rd, input word_t data, input logic wen);
   req           = '0;
   req.valid     = 1'b1;
   req.alu_wen   = wen;
   req.rf_target = rd;
   alu_res       = data;
   expect_wb(2, wen, rd, data);
endtask

task automatic set_sources(input reg_idx_t rs1, input reg_idx_t rs2,
                           input logic b_imm, input logic double_read);
   issue.rs1         = rs1;
   issue.rs2         = rs2;
   issue.rs1_data    = rand_word();
   issue.rs2_data    = rand_word();
   issue.imm_shifted = rand_word();
   issue.b_imm       = b_imm;
   issue.double_read = double_read;
endtask

// lets pending writes reach wb_w
task automatic drain();
   repeat (3) begin
      tick();
      clear_inputs();
   end
endtask

task automatic finish_test(input string name, input int errs_before);
   test_count++;
   if (err_count == errs_before) begin
      $display("test %s: ok", name);
   end else begin
      test_fail_count++;
      $display("test %s: %0d errors", name, err_count - errs_before);
   end
endtask

////////////////////////////////////////
// directed tests
////////////////////////////////////////

task automatic test_alu_writeback();
   int errs;
   int i;
   errs = err_count;
   check_word("wb_w wen after reset", word_t'(wb_w.wen), '0);
   // back to back ops where every seventh writes nothing
   for (i = 0; i < 160; i++) begin
      tick();
      issue_alu(rand_idx(), rand_word(), (i % 7) != 3);
   end
   drain();
   finish_test("alu writeback", errs);
endtask

task automatic test_forwarding();
   int errs;
   int i;
   reg_idx_t a;
   reg_idx_t b;
   word_t x [5];
   errs = err_count;
   // a is odd so neither a nor b is x0
   a = rand_idx() | 5'd1;
   b = a ^ 5'd2;
   for (i = 0; i < 5; i++) begin
      x[i] = rand_word();
   end
   tick();
   issue_alu(a, x[0], 1'b1);
   tick();
   issue_alu(a, x[1], 1'b1);
   set_sources(a, 5'd0, 1'b0, 1'b0);
   #1;
   check_word("alu_a from M", operands.alu_a, x[0]);
   check_word("lsu_base from M", operands.lsu_base, x[0]);
   check_word("alu_b from x0", operands.alu_b, issue.rs2_data);
   // a sits in both M and W
   tick();
   issue_alu(b, x[2], 1'b1);
   set_sources(a, a, 1'b0, 1'b0);
   #1;
   check_word("alu_a M over W", operands.alu_a, x[1]);
   check_word("lsu_wdata M over W", operands.lsu_wdata, x[1]);
   check_word("lsu_offset immediate", operands.lsu_offset, issue.imm_shifted);
   tick();
   issue_alu(5'd0, x[3], 1'b1);
   set_sources(a, b, 1'b0, 1'b0);
   #1;
   check_word("alu_a from W", operands.alu_a, x[1]);
   check_word("alu_b from M", operands.alu_b, x[2]);
   // x0 written in M and b in W but rs2 is an immediate
   tick();
   issue_alu(b, x[4], 1'b1);
   set_sources(5'd0, b, 1'b1, 1'b0);
   #1;
   check_word("alu_a x0 not forwarded", operands.alu_a, issue.rs1_data);
   check_word("alu_b with b_imm", operands.alu_b, issue.rs2_data);
   tick();
   issue_alu(rand_idx(), rand_word(), 1'b0);
   set_sources(b, b, 1'b0, 1'b1);
   #1;
   check_word("alu_a from M", operands.alu_a, x[4]);
   check_word("lsu_offset register", operands.lsu_offset, issue.rs2_data);
   drain();
   finish_test("forwarding", errs);
endtask

// kind 0 is a load, 1 a store ended by wr_fin and 2 a load ended by ale
task automatic run_access(input int kind);
   int wait_n;
   int k;
   reg_idx_t rd;
   word_t data;
   wait_n = rand_below(6) + 1;
   rd = rand_idx();
   data = rand_word();
   tick();
   clear_inputs();
   req.valid     = 1'b1;
   req.lsu_valid = 1'b1;
   req.lsu_wen   = (kind != 1);
   req.lsu_rd    = rd;
   #1;
   check_word("lsu valid at issue", word_t'(unit_valid.lsu), 32'd1);
   check_word("stall_req at issue", word_t'(stall_req), 32'd1);
   // alu work during the wait and a bubble just before the finish
   for (k = 1; k < wait_n; k++) begin
      tick();
      clear_inputs();
      if (k < wait_n - 1) begin
         issue_alu(rand_idx(), rand_word(), 1'b1);
      end
      #1;
      check_word("stall_req while waiting", word_t'(stall_req), 32'd1);
   end
   tick();
   issue_alu(rand_idx(), rand_word(), 1'b1);
   lsu_resp.data_valid = (kind == 0);
   lsu_resp.wr_fin     = (kind == 1);
   lsu_resp.ale        = (kind == 2);
   lsu_resp.rdata      = data;
   expect_wb(1, kind == 0, rd, data);
   #1;
   check_word("stall_req at finish", word_t'(stall_req), 32'd1);
   check_word("except at finish", word_t'(except), word_t'(kind == 2));
   tick();
   clear_inputs();
   #1;
   check_word("stall_req after finish", word_t'(stall_req), '0);
endtask

task automatic test_lsu_stall();
   int errs;
   int i;
   errs = err_count;
   for (i = 0; i < 48; i++) begin
      run_access(i % 3);
   end
   drain();
   finish_test("load/store stall", errs);
endtask

task automatic test_mul_branch();
   int errs;
   reg_idx_t rd_mul;
   reg_idx_t rd_br;
   word_t mul_data;
   word_t link;
   word_t target;
   errs = err_count;
   rd_mul = rand_idx();
   rd_br = rand_idx();
   mul_data = rand_word();
   link = rand_word();
   target = rand_word();
   tick();
   issue_alu(rd_mul, rand_word(), 1'b1);
   req.mul_valid = 1'b1;
   req.mul_wen   = 1'b1;
   // product replaces the alu value
   expect_wb(2, 1'b1, rd_mul, mul_data);
   #1;
   check_word("mul valid", word_t'(unit_valid.mul), 32'd1);
   tick();
   // product shows up in M
   mul_res_m = mul_data;
   issue_alu(rd_br, rand_word(), 1'b1);
   req.bru_valid     = 1'b1;
   bru_resp.taken    = 1'b1;
   bru_resp.brpc     = target;
   bru_resp.link_pc  = link;
   bru_resp.link_wen = 1'b1;
   expect_wb(2, 1'b1, rd_br, link);
   #1;
   check_word("br_taken", word_t'(br_taken), 32'd1);
   check_word("brpc", brpc, target);
   tick();
   clear_inputs();
   bru_resp.taken = 1'b1;
   #1;
   check_word("br_taken without branch", word_t'(br_taken), '0);
   tick();
   clear_inputs();
   req.valid     = 1'b1;
   req.bru_valid = 1'b1;
   #1;
   check_word("br_taken not taken", word_t'(br_taken), '0);
   drain();
   finish_test("mul and branch", errs);
endtask

task automatic test_exception();
   int errs;
   exccode_t code;
   errs = err_count;
   code = exccode_t'(rand_below(63) + 1);
   tick();
   clear_inputs();
   // valid rises with the timer pending
   tick();
   issue_alu(rand_idx(), rand_word(), 1'b1);
   req.lsu_valid     = 1'b1;
   req.lsu_wen       = 1'b1;
   req.bru_valid     = 1'b1;
   req.mul_valid     = 1'b1;
   req.mul_wen       = 1'b1;
   bru_resp.link_wen = 1'b1;
   trap.crmd_ie      = 1'b1;
   trap.timer_intr   = 1'b1;
   trap.exccode      = code;
   // killed op writes nothing
   expect_wb(2, 1'b0, '0, '0);
   #1;
   check_word("except on interrupt", word_t'(except), 32'd1);
   check_word("exccode on interrupt", word_t'(exccode), '0);
   check_word("lsu valid killed", word_t'(unit_valid.lsu), '0);
   check_word("bru valid killed", word_t'(unit_valid.bru), '0);
   check_word("mul valid killed", word_t'(unit_valid.mul), '0);
   check_word("stall_req killed", word_t'(stall_req), '0);
   // valid stays high so there is no new edge
   tick();
   issue_alu(rand_idx(), rand_word(), 1'b0);
   bru_resp = '0;
   #1;
   check_word("except without edge", word_t'(except), '0);
   tick();
   clear_inputs();
   tick();
   issue_alu(rand_idx(), rand_word(), 1'b1);
   req.bru_valid   = 1'b1;
   trap.timer_intr = 1'b1;
   trap.ext_intr   = 1'b1;
   #1;
   check_word("except with ie clear", word_t'(except), '0);
   check_word("bru valid with ie clear", word_t'(unit_valid.bru), 32'd1);
   tick();
   clear_inputs();
   trap.exception = 1'b1;
   trap.exccode   = code;
   #1;
   check_word("except on exception", word_t'(except), 32'd1);
   check_word("exccode passthrough", word_t'(exccode), word_t'(code));
   tick();
   clear_inputs();
   lsu_resp.ale = 1'b1;
   #1;
   check_word("except on ale", word_t'(except), 32'd1);
   drain();
   finish_test("exception and interrupt", errs);
endtask

//--- tests/tb_exu_ctl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_exu_ctl;
   import exu_pkg::*;

   localparam int clk_period   = 4;
   localparam int reset_cycles = 5;
   // tests run about 500 cycles
   localparam int timeout_cycles = 2000;
   localparam int slot_w         = 11;
   localparam int exp_depth      = 1 << slot_w;

   logic           clk;
   logic           arst_n;
   issue_t         issue;
   unit_req_t      req;
   word_t          alu_res;
   word_t          mul_res_m;
   lsu_resp_t      lsu_resp;
   bru_resp_t      bru_resp;
   trap_t          trap;
   exec_operands_t operands;
   unit_valid_t    unit_valid;
   logic           br_taken;
   word_t          brpc;
   logic           except;
   exccode_t       exccode;
   logic           stall_req;
   wb_t            wb_w;

   int cyc;
   int seed;
   int err_count;
   int test_count;
   int test_fail_count;

   `include "exu_ctl_tasks.svh"

   exu_ctl_top u_exu_ctl_top (
      .clk        (clk),
      .arst_n     (arst_n),
      .issue      (issue),
      .req        (req),
      .alu_res    (alu_res),
      .mul_res_m  (mul_res_m),
      .lsu_resp   (lsu_resp),
      .bru_resp   (bru_resp),
      .trap       (trap),
      .operands   (operands),
      .unit_valid (unit_valid),
      .br_taken   (br_taken),
      .brpc       (brpc),
      .except     (except),
      .exccode    (exccode),
      .stall_req  (stall_req),
      .wb_w       (wb_w)
   );

   ////////////////////////////////////////
   // clock, cycle count, watchdog
   ////////////////////////////////////////

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   initial begin
      wait (cyc >= timeout_cycles);
      $display("timeout: tests still running after %0d cycles", timeout_cycles);
      $display("sim failed");
      $finish;
   end

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////

   initial begin
      seed = 81291;
      arst_n = 1'b0;
      clear_inputs();
      repeat (reset_cycles) @(posedge clk);
      #1;
      arst_n = 1'b1;
      test_alu_writeback();
      test_forwarding();
      test_lsu_stall();
      test_mul_branch();
      test_exception();
      $display("%0d tests, %0d failed, %0d errors", test_count, test_fail_count, err_count);
      if (err_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+tests
verilog/exu_pkg.sv
verilog/operand_bypass.sv
verilog/issue_ctl.sv
verilog/wb_select.sv
verilog/exu_ctl_top.sv
tests/tb_exu_ctl.sv

//--- verilog/exu_ctl_top.sv
`timescale 1ns/100ps
`default_nettype none

module exu_ctl_top (
   input  wire                      clk,
   input  wire                      arst_n,
   input  wire exu_pkg::issue_t     issue,
   input  wire exu_pkg::unit_req_t  req,
   input  wire exu_pkg::word_t      alu_res,
   input  wire exu_pkg::word_t      mul_res_m,
   input  wire exu_pkg::lsu_resp_t  lsu_resp,
   input  wire exu_pkg::bru_resp_t  bru_resp,
   input  wire exu_pkg::trap_t      trap,
   output exu_pkg::exec_operands_t  operands,
   output exu_pkg::unit_valid_t     unit_valid,
   output logic                     br_taken,
   output exu_pkg::word_t           brpc,
   output logic                     except,
   output exu_pkg::exccode_t        exccode,
   output logic                     stall_req,
   output exu_pkg::wb_t             wb_w
);
   import exu_pkg::*;

   // M stage copy for forwarding
   wb_t  wb_m;
   logic kill;

   ////////////////////////////////////////
   // operand forwarding
   ////////////////////////////////////////

   operand_bypass u_operand_bypass (
      .issue    (issue),
      .wb_m     (wb_m),
      .wb_w     (wb_w),
      .operands (operands)
   );

   ////////////////////////////////////////
   // issue control
   ////////////////////////////////////////

   issue_ctl u_issue_ctl (
      .clk        (clk),
      .arst_n     (arst_n),
      .req        (req),
      .trap       (trap),
      .lsu_resp   (lsu_resp),
      .bru_taken  (bru_resp.taken),
      .unit_valid (unit_valid),
      .kill       (kill),
      .br_taken   (br_taken),
      .except     (except),
      .exccode    (exccode),
      .stall_req  (stall_req)
   );

   // branch target straight from the branch unit
   assign brpc = bru_resp.brpc;

   ////////////////////////////////////////
   // writeback
   ////////////////////////////////////////

   wb_select u_wb_select (
      .clk       (clk),
      .arst_n    (arst_n),
      .req       (req),
      .kill      (kill),
      .alu_res   (alu_res),
      .mul_res_m (mul_res_m),
      .bru_resp  (bru_resp),
      .lsu_resp  (lsu_resp),
      .wb_m      (wb_m),
      .wb_w      (wb_w)
   );

endmodule

`default_nettype wire

//--- verilog/exu_pkg.sv
`default_nettype none

package exu_pkg;

   localparam int xlen       = 32;
   localparam int reg_addr_w = 5;
   localparam int exccode_w  = 6;

   typedef logic [reg_addr_w-1:0] reg_idx_t;
   typedef logic [xlen-1:0]       word_t;
   typedef logic [exccode_w-1:0]  exccode_t;

   // interrupts report code zero
   localparam exccode_t exc_intr = '0;

   ////////////////////////////////////////
   // issue side
   ////////////////////////////////////////

   typedef struct packed {
      reg_idx_t rs1;
      reg_idx_t rs2;
      word_t    rs1_data;
      word_t    rs2_data;
      word_t    imm_shifted;
      logic     b_imm;
      logic     double_read;
   } issue_t;

   typedef struct packed {
      logic     valid;
      logic     lsu_valid;
      logic     lsu_wen;
      reg_idx_t lsu_rd;
      logic     bru_valid;
      logic     mul_valid;
      logic     mul_wen;
      logic     alu_wen;
      reg_idx_t rf_target;
   } unit_req_t;

   // kill-gated unit valids
   typedef struct packed {
      logic lsu;
      logic bru;
      logic mul;
   } unit_valid_t;

   typedef struct packed {
      word_t alu_a;
      word_t alu_b;
      word_t lsu_base;
      word_t lsu_offset;
      word_t lsu_wdata;
   } exec_operands_t;

   ////////////////////////////////////////
   // unit feedback
   ////////////////////////////////////////

   typedef struct packed {
      logic  data_valid;
      logic  wr_fin;
      logic  ale;
      word_t rdata;
   } lsu_resp_t;

   typedef struct packed {
      logic  taken;
      word_t brpc;
      word_t link_pc;
      logic  link_wen;
   } bru_resp_t;

   // one register file write
   typedef struct packed {
      logic     wen;
      reg_idx_t rd;
      word_t    data;
   } wb_t;

   typedef struct packed {
      logic     exception;
      exccode_t exccode;
      logic     crmd_ie;
      logic     timer_intr;
      logic     ext_intr;
   } trap_t;

endpackage

`default_nettype wire

//--- verilog/issue_ctl.sv
`timescale 1ns/100ps
`default_nettype none

module issue_ctl (
   input  wire                      clk,
   input  wire                      arst_n,
   input  wire exu_pkg::unit_req_t  req,
   input  wire exu_pkg::trap_t      trap,
   input  wire exu_pkg::lsu_resp_t  lsu_resp,
   input  wire                      bru_taken,
   output exu_pkg::unit_valid_t     unit_valid,
   output logic                     kill,
   output logic                     br_taken,
   output logic                     except,
   output exu_pkg::exccode_t        exccode,
   output logic                     stall_req
);
   import exu_pkg::*;

   logic prev_valid;
   logic valid_rise;
   logic intr_pend;
   logic intr_take;
   logic lsu_fin;
   logic lsu_pending;

   ////////////////////////////////////////
   // interrupt acceptance
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         prev_valid <= 1'b0;
      end else begin
         prev_valid <= req.valid;
      end
   end

   assign valid_rise = req.valid & ~prev_valid;

   // ext_intr is treated like the timer line
   assign intr_pend = (trap.timer_intr | trap.ext_intr) & trap.crmd_ie;
   assign intr_take = intr_pend & valid_rise;

   // ale stays out of kill, it depends on the gated lsu valid
   assign kill = intr_take;

   ////////////////////////////////////////
   // unit valids and exceptions
   ////////////////////////////////////////

   always_comb begin
      unit_valid.lsu = req.lsu_valid & ~kill;
      unit_valid.bru = req.bru_valid & ~kill;
      unit_valid.mul = req.mul_valid & ~kill;
   end

   assign br_taken = unit_valid.bru & bru_taken;

   // single cycle pulse toward fetch
   assign except = trap.exception | lsu_resp.ale | intr_take;

   // interrupt takes priority, the faulting instruction replays
   assign exccode = intr_take ? exc_intr : trap.exccode;

   ////////////////////////////////////////
   // load/store stall
   ////////////////////////////////////////

   // ale aborts the access, so it also ends the stall
   assign lsu_fin = lsu_resp.data_valid | lsu_resp.wr_fin | lsu_resp.ale;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lsu_pending <= 1'b0;
      end else begin
         lsu_pending <= (unit_valid.lsu | lsu_pending) & ~lsu_fin;
      end
   end

   // high from issue through the finish cycle
   assign stall_req = unit_valid.lsu | lsu_pending;

endmodule

`default_nettype wire

//--- verilog/operand_bypass.sv
`timescale 1ns/100ps
`default_nettype none

module operand_bypass (
   input  wire exu_pkg::issue_t    issue,
   input  wire exu_pkg::wb_t       wb_m,
   input  wire exu_pkg::wb_t       wb_w,
   output exu_pkg::exec_operands_t operands
);
   import exu_pkg::*;

   word_t rs1_byp;
   word_t rs2_byp;
   logic  rs2_no_fwd;

   ////////////////////////////////////////
   // forwarding
   ////////////////////////////////////////

   // M is younger than W, so it wins
   function automatic word_t fwd_src(
      input reg_idx_t rs,
      input word_t    rf_data,
      input logic     no_fwd,
      input wb_t      m,
      input wb_t      w
   );
      word_t res;
      res = rf_data;
      // x0 never bypassed
      if (!no_fwd && (rs != '0)) begin
         if (m.wen && (m.rd == rs)) begin
            res = m.data;
         end else if (w.wen && (w.rd == rs)) begin
            res = w.data;
         end
      end
      return res;
   endfunction

   // rs2 slot carries an immediate or a load/store register offset
   assign rs2_no_fwd = issue.b_imm | issue.double_read;

   assign rs1_byp = fwd_src(issue.rs1, issue.rs1_data, 1'b0, wb_m, wb_w);
   assign rs2_byp = fwd_src(issue.rs2, issue.rs2_data, rs2_no_fwd, wb_m, wb_w);

   ////////////////////////////////////////
   // routing to units
   ////////////////////////////////////////

   always_comb begin
      operands.alu_a    = rs1_byp;
      operands.alu_b    = rs2_byp;
      operands.lsu_base = rs1_byp;
      // register offset or scaled immediate
      if (issue.double_read) begin
         operands.lsu_offset = rs2_byp;
      end else begin
         operands.lsu_offset = issue.imm_shifted;
      end
      // store data
      operands.lsu_wdata = rs2_byp;
   end

endmodule

`default_nettype wire

//--- verilog/wb_select.sv
`timescale 1ns/100ps
`default_nettype none

module wb_select (
   input  wire                      clk,
   input  wire                      arst_n,
   input  wire exu_pkg::unit_req_t  req,
   input  wire                      kill,
   input  wire exu_pkg::word_t      alu_res,
   input  wire exu_pkg::word_t      mul_res_m,
   input  wire exu_pkg::bru_resp_t  bru_resp,
   input  wire exu_pkg::lsu_resp_t  lsu_resp,
   output exu_pkg::wb_t             wb_m,
   output exu_pkg::wb_t             wb_w
);
   import exu_pkg::*;

   // E to M
   word_t    alu_res_q;
   reg_idx_t rf_target_q;
   logic     alu_wen_q;
   logic     mul_valid_q;
   logic     mul_wen_q;
   word_t    link_pc_q;
   logic     bru_wen_q;

   // load destination
   logic     lsu_issue;
   reg_idx_t lsu_rd_hold;
   logic     lsu_wen_hold;

   // M to W
   logic     wen_w_q;
   reg_idx_t rd_w_q;
   word_t    data_w_q;

   ////////////////////////////////////////
   // E to M registers
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         alu_wen_q   <= 1'b0;
         mul_valid_q <= 1'b0;
         mul_wen_q   <= 1'b0;
         bru_wen_q   <= 1'b0;
      end else begin
         alu_wen_q   <= req.alu_wen & ~kill;
         mul_valid_q <= req.mul_valid & ~kill;
         mul_wen_q   <= req.mul_wen & ~kill;
         bru_wen_q   <= bru_resp.link_wen & ~kill;
      end
   end

   always_ff @(posedge clk) begin
      alu_res_q   <= alu_res;
      rf_target_q <= req.rf_target;
      link_pc_q   <= bru_resp.link_pc;
   end

   ////////////////////////////////////////
   // load destination hold
   ////////////////////////////////////////

   // loads finish late, keep rd until data_valid
   assign lsu_issue = req.lsu_valid & ~kill;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lsu_wen_hold <= 1'b0;
      end else if (lsu_issue) begin
         lsu_wen_hold <= req.lsu_wen;
      end
   end

   always_ff @(posedge clk) begin
      if (lsu_issue) begin
         lsu_rd_hold <= req.lsu_rd;
      end
   end

   ////////////////////////////////////////
   // M stage select
   ////////////////////////////////////////

   always_comb begin
      // any unit may claim the write
      wb_m.wen = alu_wen_q | (lsu_wen_hold & lsu_resp.data_valid) | bru_wen_q | mul_wen_q;

      // mul and branch link share the alu destination
      wb_m.rd = lsu_resp.data_valid ? lsu_rd_hold : rf_target_q;

      if (lsu_resp.data_valid) begin
         wb_m.data = lsu_resp.rdata;
      end else if (bru_wen_q) begin
         wb_m.data = link_pc_q;
      end else if (mul_valid_q) begin
         wb_m.data = mul_res_m;
      end else begin
         wb_m.data = alu_res_q;
      end
   end

   ////////////////////////////////////////
   // W stage
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wen_w_q <= 1'b0;
      end else begin
         wen_w_q <= wb_m.wen;
      end
   end

   always_ff @(posedge clk) begin
      rd_w_q   <= wb_m.rd;
      data_w_q <= wb_m.data;
   end

   // register file write port
   always_comb begin
      wb_w.wen  = wen_w_q;
      wb_w.rd   = rd_w_q;
      wb_w.data = data_w_q;
   end

endmodule

`default_nettype wire
